// File: Makefile
TOP := soc_bus_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into sim.log, look for the pass line"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f soc_bus.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/block_ram.sv
module block_ram (
	input logic i_clk,
	wb_if.slave s
);

	bus_pkg::data_t mem [0:(1 << bus_pkg::RAM_AW)-1];
	logic accept;
	logic [bus_pkg::RAM_AW-1:0] waddr;

	// Never stalls, so any strobe is taken
	assign accept = s.cyc && s.stb;
	// Low bits only, the decoder has checked the rest
	assign waddr = s.addr[bus_pkg::RAM_AW-1:0];

	always_ff @(posedge i_clk)
	begin
		if (accept && s.we)
			mem[waddr] <= s.wdata;
	end

	// Read port registered, old data on a write
	always_ff @(posedge i_clk)
	begin
		s.rdata <= mem[waddr];
		s.ack <= accept;
	end

	assign s.stall = 1'b0;
	assign s.err = 1'b0;

	// Decoder qualifies stb, cyc comes from the arbiter
	a_stb_in_cyc: assert property (@(posedge i_clk)
		s.stb |-> s.cyc);

endmodule

// File: hdl/bus_arbiter.sv
module bus_arbiter (
	input  logic i_clk,
	input  logic i_reset,
	wb_if.slave  m_host,
	wb_if.slave  m_cpu,
	wb_if.master o_bus
);

	// Live grant from the priority logic
	logic gnt_host;
	logic gnt_cpu;
	// Owner of the previous cycle
	logic r_gnt_host;
	logic r_gnt_cpu;

	//////////////////////////////////////////////////
	// Grant selection
	//////////////////////////////////////////////////

	// Owner keeps the bus while its cyc stays up
	// Idle bus goes to the processor first
	always_comb
	begin
		gnt_host = 1'b0;
		gnt_cpu = 1'b0;
		if (r_gnt_cpu && m_cpu.cyc)
			gnt_cpu = 1'b1;
		else if (r_gnt_host && m_host.cyc)
			gnt_host = 1'b1;
		else if (m_cpu.cyc)
			gnt_cpu = 1'b1;
		else if (m_host.cyc)
			gnt_host = 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_gnt_host <= 1'b0;
			r_gnt_cpu <= 1'b0;
		end
		else
		begin
			r_gnt_host <= gnt_host;
			r_gnt_cpu <= gnt_cpu;
		end
	end

	//////////////////////////////////////////////////
	// Request and response steering
	//////////////////////////////////////////////////

	// A grant already implies the owner's cyc
	assign o_bus.cyc = gnt_cpu || gnt_host;
	assign o_bus.stb = gnt_cpu ? m_cpu.stb : (gnt_host && m_host.stb);
	assign o_bus.we = gnt_cpu ? m_cpu.we : m_host.we;
	assign o_bus.addr = gnt_cpu ? m_cpu.addr : m_host.addr;
	assign o_bus.wdata = gnt_cpu ? m_cpu.wdata : m_host.wdata;

	// Loser sits stalled while responses go to the owner only
	assign m_cpu.ack = gnt_cpu && o_bus.ack;
	assign m_cpu.err = gnt_cpu && o_bus.err;
	assign m_cpu.stall = !gnt_cpu || o_bus.stall;
	assign m_cpu.rdata = o_bus.rdata;

	assign m_host.ack = gnt_host && o_bus.ack;
	assign m_host.err = gnt_host && o_bus.err;
	assign m_host.stall = !gnt_host || o_bus.stall;
	assign m_host.rdata = o_bus.rdata;

	// A response always finds an owner to carry it back
	a_resp_owned: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_bus.ack || o_bus.err) |-> (gnt_cpu || gnt_host));

endmodule

// File: hdl/bus_decoder.sv
module bus_decoder (
	input  logic           i_clk,
	input  logic           i_reset,
	wb_if.slave            i_bus,
	wb_if.master           o_bram,
	wb_if.master           o_io,
	wb_if.master           o_ext,
	output bus_pkg::addr_t o_err_addr
);

	// Skip bits are the external select and the block RAM bit
	logic [1:0] skipaddr;
	logic skiperr;
	logic sel_ext;
	logic sel_bram;
	logic sel_io;
	logic unmapped;
	logic accept;
	// Return side
	logic [2:0] ack_list;
	logic many_ack;
	logic slave_err;
	logic resp;
	// Addresses of accepted, still unanswered requests
	bus_pkg::addr_t pend_addr [0:(1 << bus_pkg::PEND_AW)-1];
	logic [bus_pkg::PEND_AW:0] wr_ptr;
	logic [bus_pkg::PEND_AW:0] rd_ptr;
	logic [bus_pkg::PEND_AW:0] pend_cnt;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	assign skipaddr = {i_bus.addr[bus_pkg::EXT_SEL_BIT], i_bus.addr[bus_pkg::RAM_AW]};

	// Bits between the skip bits must be clear
	// Register space also needs the block RAM offset clear
	assign skiperr = (!skipaddr[1]
			&& (i_bus.addr[bus_pkg::EXT_SEL_BIT-1:bus_pkg::RAM_AW+1]
			!= bus_pkg::BRAM_BASE[bus_pkg::EXT_SEL_BIT-1:bus_pkg::RAM_AW+1]))
		|| ((skipaddr == 2'b00)
			&& (|i_bus.addr[bus_pkg::RAM_AW-1:bus_pkg::IO_AW]));

	assign sel_ext = skipaddr[1];
	assign sel_bram = (skipaddr == 2'b01) && !skiperr;
	// Register word 3 falls outside the map
	assign sel_io = (skipaddr == 2'b00) && !skiperr
		&& (i_bus.addr[bus_pkg::IO_AW-1:0] <= bus_pkg::IO_LAST[bus_pkg::IO_AW-1:0]);
	assign unmapped = !(sel_ext || sel_bram || sel_io);

	// Stall comes straight from the selected slave
	assign i_bus.stall = i_bus.cyc && ((sel_ext && o_ext.stall)
		|| (sel_bram && o_bram.stall) || (sel_io && o_io.stall));
	assign accept = i_bus.cyc && i_bus.stb && !i_bus.stall;

	// Shared request with the strobe qualified per slave
	assign o_bram.cyc = i_bus.cyc;
	assign o_bram.stb = i_bus.stb && sel_bram;
	assign o_bram.we = i_bus.we;
	assign o_bram.addr = i_bus.addr;
	assign o_bram.wdata = i_bus.wdata;

	assign o_io.cyc = i_bus.cyc;
	assign o_io.stb = i_bus.stb && sel_io;
	assign o_io.we = i_bus.we;
	assign o_io.addr = i_bus.addr;
	assign o_io.wdata = i_bus.wdata;

	assign o_ext.cyc = i_bus.cyc;
	assign o_ext.stb = i_bus.stb && sel_ext;
	assign o_ext.we = i_bus.we;
	assign o_ext.addr = i_bus.addr;
	assign o_ext.wdata = i_bus.wdata;

	//////////////////////////////////////////////////
	// Registered return and bus errors
	//////////////////////////////////////////////////

	assign ack_list = {o_ext.ack, o_bram.ack, o_io.ack};
	// More than one bit set
	assign many_ack = (ack_list & (ack_list - 3'd1)) != 3'd0;
	assign slave_err = o_ext.err || o_bram.err || o_io.err;
	assign resp = (|ack_list) || slave_err;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			i_bus.ack <= 1'b0;
			i_bus.err <= 1'b0;
		end
		else
		begin
			// Unmapped strobe answers one cycle after acceptance
			i_bus.err <= i_bus.cyc
				&& ((accept && unmapped) || many_ack || slave_err);
			i_bus.ack <= i_bus.cyc && (|ack_list) && !many_ack
				&& !slave_err && !(accept && unmapped);
		end
	end

	// Read data mux with external RAM first
	always_ff @(posedge i_clk)
	begin
		if (o_ext.ack)
			i_bus.rdata <= o_ext.rdata;
		else if (o_bram.ack)
			i_bus.rdata <= o_bram.rdata;
		else
			i_bus.rdata <= o_io.rdata;
	end

	//////////////////////////////////////////////////
	// Error address capture
	//////////////////////////////////////////////////

	// Slaves answer in order, so the head is the responder
	// Dropping cyc abandons whatever is in flight
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_bus.cyc)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (accept && !unmapped)
				wr_ptr <= wr_ptr + 1'b1;
			if (resp)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (accept && !unmapped)
			pend_addr[wr_ptr[bus_pkg::PEND_AW-1:0]] <= i_bus.addr;
	end

	assign pend_cnt = wr_ptr - rd_ptr;

	// Same edge as the err it explains
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_err_addr <= '0;
		else if (accept && unmapped)
			o_err_addr <= i_bus.addr;
		else if (i_bus.cyc && (many_ack || slave_err))
			o_err_addr <= pend_addr[rd_ptr[bus_pkg::PEND_AW-1:0]];
	end

	// Masters never run more requests ahead than the address queue holds
	a_pend_room: assert property (@(posedge i_clk) disable iff (i_reset)
		(accept && !unmapped) |-> !pend_cnt[bus_pkg::PEND_AW]);

endmodule

// File: hdl/bus_pkg.sv
package bus_pkg;

	//////////////////////////////////////////////////
	// Bus widths and payload types
	//////////////////////////////////////////////////

	// Word address, no byte lanes
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Internal block RAM, 1 kW
	localparam int RAM_AW = 10;

	// External RAM window, upper half of the map
	localparam int EXT_AW = 15;

	typedef logic [EXT_AW-1:0] ext_addr_t;

	// Board switches and LEDs
	localparam int LED_W = 4;

	typedef logic [LED_W-1:0] led_t;

	//////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////

	// Top bit alone selects the external RAM
	localparam int EXT_SEL_BIT = 15;
	// Block RAM sits at 0x0400, bit RAM_AW is its skip bit
	localparam addr_t BRAM_BASE = 16'h0400;
	// Highest mapped register word
	localparam addr_t IO_LAST = 16'h0002;

	// Register block word index
	localparam int IO_AW = 2;
	localparam logic [IO_AW-1:0] IO_SW = 2'd0;
	localparam logic [IO_AW-1:0] IO_LED = 2'd1;
	localparam logic [IO_AW-1:0] IO_ERRADDR = 2'd2;

	// Outstanding requests tracked by the decoder, log2
	localparam int PEND_AW = 2;

endpackage

// File: hdl/io_regs.sv
module io_regs (
	input  logic          i_clk,
	input  logic          i_reset,
	wb_if.slave           s,
	input  bus_pkg::led_t  i_sw,
	input  bus_pkg::addr_t i_err_addr,
	output bus_pkg::led_t  o_led
);

	logic accept;
	logic [bus_pkg::IO_AW-1:0] idx;

	assign accept = s.cyc && s.stb;
	assign idx = s.addr[bus_pkg::IO_AW-1:0];

	// LED register, plus the one-cycle ack
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_led <= '0;
			s.ack <= 1'b0;
		end
		else
		begin
			s.ack <= accept;
			// Writes elsewhere are acked and dropped
			if (accept && s.we && (idx == bus_pkg::IO_LED))
				o_led <= s.wdata[bus_pkg::LED_W-1:0];
		end
	end

	// Read mux, zero-extended to the bus width
	always_ff @(posedge i_clk)
	begin
		case (idx)
			bus_pkg::IO_SW:
				s.rdata <= bus_pkg::data_t'(i_sw);
			bus_pkg::IO_LED:
				s.rdata <= bus_pkg::data_t'(o_led);
			bus_pkg::IO_ERRADDR:
				s.rdata <= bus_pkg::data_t'(i_err_addr);
			default:
				s.rdata <= '0;
		endcase
	end

	// Single-cycle block, no wait states
	assign s.stall = 1'b0;
	assign s.err = 1'b0;

endmodule

// File: hdl/soc_bus.sv
module soc_bus (
	input  logic              i_clk,
	input  logic              i_reset,
	// Debug host master
	input  logic              i_host_cyc,
	input  logic              i_host_stb,
	input  logic              i_host_we,
	input  bus_pkg::addr_t    i_host_addr,
	input  bus_pkg::data_t    i_host_wdata,
	output logic              o_host_ack,
	output logic              o_host_stall,
	output logic              o_host_err,
	output bus_pkg::data_t    o_host_rdata,
	// Processor master
	input  logic              i_cpu_cyc,
	input  logic              i_cpu_stb,
	input  logic              i_cpu_we,
	input  bus_pkg::addr_t    i_cpu_addr,
	input  bus_pkg::data_t    i_cpu_wdata,
	output logic              o_cpu_ack,
	output logic              o_cpu_stall,
	output logic              o_cpu_err,
	output bus_pkg::data_t    o_cpu_rdata,
	// Board I/O
	input  bus_pkg::led_t     i_sw,
	output bus_pkg::led_t     o_led,
	// External RAM
	output logic              o_ram_cyc,
	output logic              o_ram_stb,
	output logic              o_ram_we,
	output bus_pkg::ext_addr_t o_ram_addr,
	output bus_pkg::data_t    o_ram_wdata,
	input  logic              i_ram_ack,
	input  logic              i_ram_stall,
	input  logic              i_ram_err,
	input  bus_pkg::data_t    i_ram_rdata
);

	wb_if arb_host ();
	wb_if arb_cpu ();
	wb_if bus ();
	wb_if s_bram ();
	wb_if s_io ();
	wb_if s_ext ();

	bus_pkg::addr_t err_addr;

	//////////////////////////////////////////////////
	// Master ports
	//////////////////////////////////////////////////

	assign arb_host.cyc = i_host_cyc;
	assign arb_host.stb = i_host_stb;
	assign arb_host.we = i_host_we;
	assign arb_host.addr = i_host_addr;
	assign arb_host.wdata = i_host_wdata;
	assign o_host_ack = arb_host.ack;
	assign o_host_stall = arb_host.stall;
	assign o_host_err = arb_host.err;
	assign o_host_rdata = arb_host.rdata;

	assign arb_cpu.cyc = i_cpu_cyc;
	assign arb_cpu.stb = i_cpu_stb;
	assign arb_cpu.we = i_cpu_we;
	assign arb_cpu.addr = i_cpu_addr;
	assign arb_cpu.wdata = i_cpu_wdata;
	assign o_cpu_ack = arb_cpu.ack;
	assign o_cpu_stall = arb_cpu.stall;
	assign o_cpu_err = arb_cpu.err;
	assign o_cpu_rdata = arb_cpu.rdata;

	// External RAM sees the window offset only
	assign o_ram_cyc = s_ext.cyc;
	assign o_ram_stb = s_ext.stb;
	assign o_ram_we = s_ext.we;
	assign o_ram_addr = s_ext.addr[bus_pkg::EXT_AW-1:0];
	assign o_ram_wdata = s_ext.wdata;
	assign s_ext.ack = i_ram_ack;
	assign s_ext.stall = i_ram_stall;
	assign s_ext.err = i_ram_err;
	assign s_ext.rdata = i_ram_rdata;

	//////////////////////////////////////////////////
	// Interconnect
	//////////////////////////////////////////////////

	bus_arbiter u_arbiter (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.m_host  (arb_host.slave),
		.m_cpu   (arb_cpu.slave),
		.o_bus   (bus.master)
	);

	bus_decoder u_decoder (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_bus      (bus.slave),
		.o_bram     (s_bram.master),
		.o_io       (s_io.master),
		.o_ext      (s_ext.master),
		.o_err_addr (err_addr)
	);

	block_ram u_bram (
		.i_clk (i_clk),
		.s     (s_bram.slave)
	);

	io_regs u_io (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.s          (s_io.slave),
		.i_sw       (i_sw),
		.i_err_addr (err_addr),
		.o_led      (o_led)
	);

endmodule

// File: hdl/wb_if.sv
interface wb_if;

	// Request side
	logic cyc;
	logic stb;
	logic we;
	bus_pkg::addr_t addr;
	bus_pkg::data_t wdata;

	// Response side
	logic ack;
	logic stall;
	bus_pkg::data_t rdata;
	logic err;

	// Master drives the request
	modport master (
		output cyc,
		output stb,
		output we,
		output addr,
		output wdata,
		input  ack,
		input  stall,
		input  rdata,
		input  err
	);

	// Slave answers with ack or err, and may stall
	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  addr,
		input  wdata,
		output ack,
		output stall,
		output rdata,
		output err
	);

endinterface

// File: soc_bus.f
hdl/bus_pkg.sv
hdl/wb_if.sv
hdl/bus_arbiter.sv
hdl/bus_decoder.sv
hdl/block_ram.sv
hdl/io_regs.sv
hdl/soc_bus.sv
verification/soc_bus_tb.sv

// File: verification/soc_bus_tb.sv
module soc_bus_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_TRANS = 200;
	localparam int SEED = 379;
	localparam int RESET_CYCLES = 16;
	// 400 transactions at up to 40 cycles each with some margin
	localparam int MAX_CYCLES = 20000;

	// Request regions
	localparam int REG_IO = 0;
	localparam int REG_BRAM = 1;
	localparam int REG_EXT = 2;
	localparam int REG_NONE = 3;

	logic i_clk = 1'b0;
	logic i_reset;
	// Master side with index 0 for the host and 1 for the processor
	logic [1:0] m_cyc;
	logic [1:0] m_stb;
	logic [1:0] m_we;
	bus_pkg::addr_t m_addr [0:1];
	bus_pkg::data_t m_wdata [0:1];
	logic [1:0] s_ack;
	logic [1:0] s_stall;
	logic [1:0] s_err;
	bus_pkg::data_t host_rdata;
	bus_pkg::data_t cpu_rdata;
	// Board and external RAM
	bus_pkg::led_t i_sw;
	bus_pkg::led_t o_led;
	logic o_ram_cyc;
	logic o_ram_stb;
	logic o_ram_we;
	bus_pkg::ext_addr_t o_ram_addr;
	bus_pkg::data_t o_ram_wdata;
	logic i_ram_ack;
	logic i_ram_stall;
	logic i_ram_err;
	bus_pkg::data_t i_ram_rdata;

	// What the RAM responder saw and did last
	bus_pkg::ext_addr_t ram_seen_addr;
	logic ram_seen_we;
	bus_pkg::data_t ram_seen_wdata;
	logic ram_sent_err;
	int ram_lat;
	bus_pkg::data_t ram_mem [bus_pkg::ext_addr_t];

	// Reference model
	bus_pkg::data_t bram_model [bus_pkg::addr_t];
	bus_pkg::data_t ext_model [bus_pkg::ext_addr_t];
	bus_pkg::led_t led_model;
	bus_pkg::addr_t err_model;

	int cycle_cnt;

	soc_bus u_soc_bus (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_host_cyc   (m_cyc[0]),
		.i_host_stb   (m_stb[0]),
		.i_host_we    (m_we[0]),
		.i_host_addr  (m_addr[0]),
		.i_host_wdata (m_wdata[0]),
		.o_host_ack   (s_ack[0]),
		.o_host_stall (s_stall[0]),
		.o_host_err   (s_err[0]),
		.o_host_rdata (host_rdata),
		.i_cpu_cyc    (m_cyc[1]),
		.i_cpu_stb    (m_stb[1]),
		.i_cpu_we     (m_we[1]),
		.i_cpu_addr   (m_addr[1]),
		.i_cpu_wdata  (m_wdata[1]),
		.o_cpu_ack    (s_ack[1]),
		.o_cpu_stall  (s_stall[1]),
		.o_cpu_err    (s_err[1]),
		.o_cpu_rdata  (cpu_rdata),
		.i_sw         (i_sw),
		.o_led        (o_led),
		.o_ram_cyc    (o_ram_cyc),
		.o_ram_stb    (o_ram_stb),
		.o_ram_we     (o_ram_we),
		.o_ram_addr   (o_ram_addr),
		.o_ram_wdata  (o_ram_wdata),
		.i_ram_ack    (i_ram_ack),
		.i_ram_stall  (i_ram_stall),
		.i_ram_err    (i_ram_err),
		.i_ram_rdata  (i_ram_rdata)
	);

	always #10 i_clk = ~i_clk;

	//////////////////////////////////////////////////
	// Error reporting and compares
	//////////////////////////////////////////////////

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic report_error(input string what);
		$display("Error: %s", what);
		stop_run();
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_data(input string name, input bus_pkg::data_t got,
		input bus_pkg::data_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_led(input string name, input bus_pkg::led_t got,
		input bus_pkg::led_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input bus_pkg::addr_t got,
		input bus_pkg::addr_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_ext_addr(input string name, input bus_pkg::ext_addr_t got,
		input bus_pkg::ext_addr_t exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	// Unwritten external words read back as a pattern of the address
	function automatic bus_pkg::data_t ext_fill(input bus_pkg::ext_addr_t a);
		return {1'b0, ~a, 1'b1, a};
	endfunction

	// No response may arrive while nothing is outstanding
	task automatic check_quiet(input bit id);
		if (s_ack[id] || s_err[id])
			report_error($sformatf("%s master got a response with no request accepted",
				id ? "cpu" : "host"));
	endtask

	//////////////////////////////////////////////////
	// Model update and response checks
	//////////////////////////////////////////////////

	task automatic check_response(input bit id, input int region, input bus_pkg::addr_t addr,
		input logic we, input bus_pkg::data_t wdata, input bus_pkg::data_t rdata,
		input logic got_ack, input logic got_err, input int lat,
		input bus_pkg::led_t sw_seen);
		bus_pkg::data_t exp;
		bus_pkg::ext_addr_t a;
		logic exp_err;
		int exp_lat;
		string who;
		who = id ? "cpu" : "host";
		a = addr[bus_pkg::EXT_AW-1:0];
		if (got_ack && got_err)
			report_error($sformatf("%s master got ack and err together", who));
		exp_err = (region == REG_NONE) || ((region == REG_EXT) && ram_sent_err);
		// Unmapped errs come straight away and internal slaves take two cycles
		if (region == REG_NONE)
			exp_lat = 1;
		else if (region == REG_EXT)
			exp_lat = ram_lat + 1;
		else
			exp_lat = 2;
		check_flag($sformatf("o_%s_err", who), got_err, exp_err);
		if (lat != exp_lat)
			report_error($sformatf("%s master at 0x%h answered after %0d cycles, not %0d",
				who, addr, lat, exp_lat));
		// External request as it left the top level
		if (region == REG_EXT)
		begin
			check_ext_addr("o_ram_addr", ram_seen_addr, a);
			check_flag("o_ram_we", ram_seen_we, we);
			if (we)
				check_data("o_ram_wdata", ram_seen_wdata, wdata);
		end
		if (exp_err)
			err_model = addr;
		else if (region == REG_BRAM)
		begin
			if (we)
				bram_model[addr] = wdata;
			else if (bram_model.exists(addr))
				check_data($sformatf("o_%s_rdata", who), rdata, bram_model[addr]);
		end
		else if (region == REG_EXT)
		begin
			if (we)
				ext_model[a] = wdata;
			else
			begin
				exp = ext_model.exists(a) ? ext_model[a] : ext_fill(a);
				check_data($sformatf("o_%s_rdata", who), rdata, exp);
			end
		end
		else
		begin
			case (addr[bus_pkg::IO_AW-1:0])
				bus_pkg::IO_LED:
					if (we)
						led_model = wdata[bus_pkg::LED_W-1:0];
					else
						check_data($sformatf("o_%s_rdata", who), rdata,
							bus_pkg::data_t'(led_model));
				bus_pkg::IO_SW:
					if (!we)
						check_data($sformatf("o_%s_rdata", who), rdata,
							bus_pkg::data_t'(sw_seen));
				default:
					if (!we)
					begin
						check_addr($sformatf("o_%s_rdata", who),
							rdata[bus_pkg::ADDR_W-1:0], err_model);
						check_data($sformatf("o_%s_rdata", who), rdata,
							bus_pkg::data_t'(err_model));
					end
			endcase
		end
		// Writes to read-only words leave the LEDs alone
		check_led("o_led", o_led, led_model);
	endtask

	//////////////////////////////////////////////////
	// Masters, RAM responder, switches
	//////////////////////////////////////////////////

	task automatic run_master(input bit id);
		int n;
		int gap;
		int lat;
		int region;
		int pick;
		logic we;
		logic got_ack;
		logic got_err;
		bus_pkg::addr_t addr;
		bus_pkg::data_t wdata;
		bus_pkg::data_t rdata;
		bus_pkg::led_t sw_seen;
		for (n = 0; n < N_TRANS; n++)
		begin
			// At least one idle cycle so each request gets its own cyc
			gap = $urandom_range(1, 6);
			repeat (gap)
			begin
				@(posedge i_clk);
				check_quiet(id);
			end
			region = $urandom_range(0, 3);
			we = 1'($urandom_range(0, 1));
			wdata = $urandom();
			case (region)
				REG_IO:
					addr = 16'($urandom_range(0, int'(bus_pkg::IO_LAST)));
				REG_BRAM:
					addr = bus_pkg::BRAM_BASE
						| {6'd0, ($urandom_range(0, 1) != 0) ? 5'h1f : 5'h00, 5'($urandom)};
				REG_EXT:
					addr = {1'b1, ($urandom_range(0, 1) != 0) ? 9'h1ff : 9'h000,
						6'($urandom)};
				default:
				begin
					// Register word 3 or one of the gaps below and above the RAM
					pick = $urandom_range(0, 2);
					if (pick == 0)
						addr = bus_pkg::IO_LAST + 16'd1;
					else if (pick == 1)
						addr = 16'h0004 + 16'($urandom_range(0, 16'h03fb));
					else
						addr = 16'h0800 + 16'($urandom_range(0, 16'h77ff));
				end
			endcase
			m_cyc[id] <= 1'b1;
			m_stb[id] <= 1'b1;
			m_we[id] <= we;
			m_addr[id] <= addr;
			m_wdata[id] <= wdata;
			// Strobe held through lost arbitration and slave stall
			do
			begin
				@(posedge i_clk);
				check_quiet(id);
			end while (s_stall[id]);
			sw_seen = i_sw;
			m_stb[id] <= 1'b0;
			lat = 0;
			do
			begin
				@(posedge i_clk);
				lat++;
			end while (!s_ack[id] && !s_err[id]);
			got_ack = s_ack[id];
			got_err = s_err[id];
			rdata = id ? cpu_rdata : host_rdata;
			m_cyc[id] <= 1'b0;
			check_response(id, region, addr, we, wdata, rdata, got_ack, got_err, lat,
				sw_seen);
		end
	endtask

	// One request in flight at a time with ack or err 1 to 6 cycles later
	task automatic respond_ext();
		int wait_cnt;
		wait_cnt = 0;
		forever
		begin
			@(posedge i_clk);
			i_ram_ack <= 1'b0;
			i_ram_err <= 1'b0;
			if (o_ram_cyc && o_ram_stb && !i_ram_stall)
			begin
				ram_seen_addr = o_ram_addr;
				ram_seen_we = o_ram_we;
				ram_seen_wdata = o_ram_wdata;
				wait_cnt = $urandom_range(1, 6);
				ram_lat = wait_cnt;
			end
			if (wait_cnt > 0)
			begin
				wait_cnt--;
				if (wait_cnt == 0)
				begin
					ram_sent_err = ($urandom_range(0, 7) == 0);
					if (ram_sent_err)
						i_ram_err <= 1'b1;
					else
					begin
						i_ram_ack <= 1'b1;
						if (ram_seen_we)
							ram_mem[ram_seen_addr] = ram_seen_wdata;
						else if (ram_mem.exists(ram_seen_addr))
							i_ram_rdata <= ram_mem[ram_seen_addr];
						else
							i_ram_rdata <= ext_fill(ram_seen_addr);
					end
				end
			end
			i_ram_stall <= ($urandom_range(0, 3) == 0);
		end
	endtask

	task automatic change_switches();
		forever
		begin
			repeat ($urandom_range(5, 30)) @(posedge i_clk);
			i_sw <= bus_pkg::led_t'($urandom);
		end
	endtask

	//////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES)
			report_error($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
	end

	initial
	begin
		void'($urandom(SEED));
		cycle_cnt = 0;
		led_model = '0;
		err_model = '0;
		i_reset <= 1'b1;
		m_cyc <= '0;
		m_stb <= '0;
		m_we <= '0;
		m_addr[0] <= '0;
		m_addr[1] <= '0;
		m_wdata[0] <= '0;
		m_wdata[1] <= '0;
		i_sw <= bus_pkg::led_t'($urandom);
		i_ram_ack <= 1'b0;
		i_ram_stall <= 1'b0;
		i_ram_err <= 1'b0;
		i_ram_rdata <= '0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		// Outputs still in reset on the last reset edge
		if (s_ack != 2'b00 || s_err != 2'b00)
			report_error("a master sees ack or err during reset");
		if (o_ram_cyc || o_ram_stb)
			report_error("external RAM cyc or stb is high during reset");
		if (s_stall != 2'b11)
			report_error("a master holds the grant during reset");
		check_led("o_led", o_led, '0);
		i_reset <= 1'b0;
		fork
			respond_ext();
			change_switches();
		join_none
		fork
			run_master(1'b0);
			run_master(1'b1);
		join
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
